// ==== hdl/fusion_pkg.sv ====
package fusion_pkg;

    //////////////////////////////////////////////////////////////////////
    // datapath widths
    //////////////////////////////////////////////////////////////////////

    // operand and product vector widths
    localparam int OPERAND_W    = 8;
    localparam int PRODUCT_W    = 64;
    localparam int ACC_W        = 128;

    // accumulator lane widths per precision
    localparam int FIELD2_ACC_W = 8;
    localparam int NIBBLE_ACC_W = 12;
    localparam int FULL_ACC_W   = 20;

    //////////////////////////////////////////////////////////////////////
    // axi4-lite register block
    //////////////////////////////////////////////////////////////////////

    localparam int AXIL_ADDR_W  = 4;
    localparam int AXIL_DATA_W  = 32;

    // byte address of the precision mode register
    localparam logic [AXIL_ADDR_W-1:0] MODE_ADDR = '0;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // plain vectors with a meaning
    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [PRODUCT_W-1:0] product_vec_t;
    typedef logic [ACC_W-1:0]     acc_vec_t;
    // one flag per brick, indexed block*4 + brick
    typedef logic [15:0]          brick_signs_t;

    // precision mode, value 3 is invalid
    typedef enum logic [1:0] {
        MODE_2X2 = 2'd0,
        MODE_4X4 = 2'd1,
        MODE_8X8 = 2'd2
    } prec_mode_t;

    // one operand sample, no back-pressure
    typedef struct packed {
        logic     valid;
        operand_t x;
        operand_t y;
    } mac_in_t;

    // manager to subordinate
    typedef struct packed {
        logic                     awvalid;
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     wvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     bready;
        logic                     arvalid;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     rready;
    } axil_req_t;

    // subordinate to manager
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
    } axil_rsp_t;

endpackage

// ==== hdl/bit_brick.sv ====
`timescale 1ns/1ps

module bit_brick (
    input  logic [1:0] x,
    input  logic [1:0] y,
    input  logic       sx,
    input  logic       sy,
    output logic [4:0] p
);

    // operands widened to 3 bits, top bit set only for a signed field
    logic [2:0] xi;
    logic [2:0] yi;

    // baugh-wooley partial product rows, one per bit of yi
    logic [2:0] pp0;
    logic [2:0] pp1;
    logic [2:0] pp2;

    // reduction tree internals
    logic c1;
    logic s2a;
    logic c2a;
    logic c2b;
    logic s3a;
    logic c3a;
    logic c3b;

    assign xi = {sx & x[1], x};
    assign yi = {sy & y[1], y};

    // sign row and sign column terms are inverted, sign*sign is not
    assign pp0 = {~(xi[2] & yi[0]), xi[1] & yi[0], xi[0] & yi[0]};
    assign pp1 = {~(xi[2] & yi[1]), xi[1] & yi[1], xi[0] & yi[1]};
    assign pp2 = {xi[2] & yi[2], ~(xi[1] & yi[2]), ~(xi[0] & yi[2])};

    //////////////////////////////////////////////////////////////////////
    // partial product reduction
    //////////////////////////////////////////////////////////////////////

    // weight 0 passes straight through
    assign p[0] = pp0[0];

    // weight 1, half adder
    assign p[1] = pp0[1] ^ pp1[0];
    assign c1   = pp0[1] & pp1[0];

    // weight 2, full adder on the two inner terms and the carry
    assign s2a = pp1[1] ^ pp2[0] ^ c1;
    assign c2a = (pp1[1] & pp2[0]) | (pp1[1] & c1) | (pp2[0] & c1);
    // then a half adder folds in the first row
    assign p[2] = pp0[2] ^ s2a;
    assign c2b  = pp0[2] & s2a;

    // weight 3, full adder on row terms and carry
    assign s3a = pp1[2] ^ pp2[1] ^ c2a;
    assign c3a = (pp1[2] & pp2[1]) | (pp1[2] & c2a) | (pp2[1] & c2a);
    // second full adder takes the constant correction one
    assign p[3] = ~(s3a ^ c2b);
    assign c3b  = s3a | c2b;

    // top bit from the last column
    // the 2^5 correction term falls outside the 5-bit result
    assign p[4] = pp2[2] ^ c3a ^ c3b;

endmodule

// ==== hdl/fusion_block.sv ====
`timescale 1ns/1ps

module fusion_block (
    input  logic [3:0]      x_nib,
    input  logic [3:0]      y_nib,
    input  logic [3:0]      sx,
    input  logic [3:0]      sy,
    output logic [3:0][3:0] brick_p,
    output logic [7:0]      nib_p
);

    // full 5-bit brick products
    // index 3 = hi*hi, 2 = hi*lo, 1 = lo*hi, 0 = lo*lo
    logic [3:0][4:0] bp;

    // merge terms
    logic [7:0] base_word;
    logic [5:0] cross_sum;

    //////////////////////////////////////////////////////////////////////
    // four 2x2 bricks
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < 4; k++) begin : g_brick
        // x field follows the upper index bit, y field the lower
        bit_brick u_brick (
            .x  (x_nib[2*(k/2) +: 2]),
            .y  (y_nib[2*(k%2) +: 2]),
            .sx (sx[k]),
            .sy (sy[k]),
            .p  (bp[k])
        );

        // 2x2 lanes fit in 4 bits
        // largest magnitude is (-2)*(-2) = 4
        assign brick_p[k] = bp[k][3:0];
    end

    //////////////////////////////////////////////////////////////////////
    // merge and shift into the nibble product
    //////////////////////////////////////////////////////////////////////

    // hi*hi sits at weight 16, lo*lo at weight 1
    // lo*lo is unsigned here so 4 bits hold it without loss
    assign base_word = {bp[3][3:0], bp[0][3:0]};

    // cross bricks are signed 5-bit values
    // extend one bit before adding so the sum cannot overflow
    assign cross_sum = {bp[2][4], bp[2]} + {bp[1][4], bp[1]};

    // cross terms live at weight 4
    // the top carry drops out modulo 256
    assign nib_p = base_word + {cross_sum, 2'b00};

endmodule

// ==== hdl/fusion_unit.sv ====
`timescale 1ns/1ps

module fusion_unit (
    input  fusion_pkg::prec_mode_t   mode,
    input  fusion_pkg::mac_in_t      in,
    output fusion_pkg::product_vec_t product,
    output logic                     product_valid
);
    import fusion_pkg::*;

    // per-brick sign flags
    brick_signs_t x_signs;
    brick_signs_t y_signs;

    // block outputs, index 3 = xh*yh down to 0 = xl*yl
    logic [3:0][15:0] brick_lanes;
    logic [3:0][7:0]  nib_p;

    // 8x8 merge
    logic [11:0] cross_sum;
    logic [15:0] full_p;

    //////////////////////////////////////////////////////////////////////
    // sign flag decode
    //////////////////////////////////////////////////////////////////////

    // brick i uses x field {i[3], i[1]} and y field {i[2], i[0]}
    // a field is signed only when it is the top field at this precision
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            case (mode)
                MODE_2X2: begin
                    // every field is a whole operand
                    x_signs[i] = 1'b1;
                    y_signs[i] = 1'b1;
                end
                MODE_4X4: begin
                    // upper field of each nibble
                    x_signs[i] = i[1];
                    y_signs[i] = i[0];
                end
                MODE_8X8: begin
                    // only the field holding bit 7
                    x_signs[i] = i[3] & i[1];
                    y_signs[i] = i[2] & i[0];
                end
                default: begin
                    x_signs[i] = 1'b0;
                    y_signs[i] = 1'b0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // four 4x4 fusion blocks
    //////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < 4; b++) begin : g_block
        // x nibble from the upper index bit, y nibble from the lower
        fusion_block u_block (
            .x_nib   (in.x[4*(b/2) +: 4]),
            .y_nib   (in.y[4*(b%2) +: 4]),
            .sx      (x_signs[4*b +: 4]),
            .sy      (y_signs[4*b +: 4]),
            .brick_p (brick_lanes[b]),
            .nib_p   (nib_p[b])
        );
    end

    // cross nibble products are signed 8-bit, extend before adding
    assign cross_sum = {{4{nib_p[2][7]}}, nib_p[2]} + {{4{nib_p[1][7]}}, nib_p[1]};

    // xh*yh at weight 256, xl*yl unsigned at weight 1, cross terms at 16
    assign full_p = {nib_p[3], nib_p[0]} + {cross_sum, 4'b0000};

    //////////////////////////////////////////////////////////////////////
    // product vector mapping
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        product = '0;
        case (mode)
            MODE_8X8: product[15:0] = full_p;
            // four nibble products in the upper half
            MODE_4X4: product[63:32] = nib_p;
            // sixteen brick lanes, highest block first
            MODE_2X2: product = brick_lanes;
            default: product = '0;
        endcase
    end

    // product is combinational so valid travels alongside
    assign product_valid = in.valid;

endmodule

// ==== hdl/lane_accumulator.sv ====
`timescale 1ns/1ps

module lane_accumulator (
    input  logic                     clk,
    input  logic                     nrst,
    input  fusion_pkg::prec_mode_t   mode,
    input  logic                     acc_clear,
    input  fusion_pkg::product_vec_t product,
    input  logic                     product_valid,
    output fusion_pkg::acc_vec_t     sum
);
    import fusion_pkg::*;

    // next value for a valid sample
    acc_vec_t sum_next;

    //////////////////////////////////////////////////////////////////////
    // per-mode lane adds
    //////////////////////////////////////////////////////////////////////

    // lanes are packed from the top of sum downwards
    // bits outside the active lanes start from zero
    always_comb begin
        sum_next = '0;
        case (mode)
            MODE_8X8: begin
                // single 20-bit lane at the top
                sum_next[ACC_W-1 -: FULL_ACC_W] = sum[ACC_W-1 -: FULL_ACC_W]
                    + {{(FULL_ACC_W-16){product[15]}}, product[15:0]};
            end
            MODE_4X4: begin
                // four 12-bit lanes above bit 80
                // lane i takes the 8-bit product at 32 + 8*i
                for (int i = 0; i < 4; i++) begin
                    sum_next[ACC_W-4*NIBBLE_ACC_W+NIBBLE_ACC_W*i +: NIBBLE_ACC_W] =
                        sum[ACC_W-4*NIBBLE_ACC_W+NIBBLE_ACC_W*i +: NIBBLE_ACC_W]
                        + {{(NIBBLE_ACC_W-8){product[32+8*i+7]}}, product[32+8*i +: 8]};
                end
            end
            MODE_2X2: begin
                // sixteen 8-bit lanes over all of sum
                for (int i = 0; i < 16; i++) begin
                    sum_next[FIELD2_ACC_W*i +: FIELD2_ACC_W] =
                        sum[FIELD2_ACC_W*i +: FIELD2_ACC_W]
                        + {{(FIELD2_ACC_W-4){product[4*i+3]}}, product[4*i +: 4]};
                end
            end
            // invalid mode zeroes every lane
            default: sum_next = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // accumulator register
    //////////////////////////////////////////////////////////////////////

    // clear beats a coincident sample
    always_ff @(posedge clk) begin
        if (!nrst) begin
            sum <= '0;
        end else if (acc_clear) begin
            sum <= '0;
        end else if (product_valid) begin
            sum <= sum_next;
        end
    end

    // a new lane layout only ever starts from a cleared accumulator
    a_mode_change_clears: assert property (
        @(posedge clk) disable iff (!nrst) !$stable(mode) |-> acc_clear
    ) else $error("mode changed without acc_clear");

endmodule

// ==== hdl/mode_regs.sv ====
`timescale 1ns/1ps

module mode_regs (
    input  logic                   clk,
    input  logic                   nrst,
    input  fusion_pkg::axil_req_t  axil_req,
    output fusion_pkg::axil_rsp_t  axil_rsp,
    output fusion_pkg::prec_mode_t mode,
    output logic                   acc_clear
);
    import fusion_pkg::*;

    // write channel state
    logic aw_ready;
    logic b_valid;
    logic [1:0] b_resp;

    // read channel state
    logic ar_ready;
    logic r_valid;
    logic [AXIL_DATA_W-1:0] r_data;
    logic [1:0] r_resp;

    // handshakes and decode
    logic wr_fire;
    logic rd_fire;
    logic wr_hit;
    logic rd_hit;

    assign wr_fire = aw_ready & axil_req.awvalid & axil_req.wvalid;
    assign rd_fire = ar_ready & axil_req.arvalid;
    assign wr_hit  = (axil_req.awaddr == MODE_ADDR);
    assign rd_hit  = (axil_req.araddr == MODE_ADDR);

    //////////////////////////////////////////////////////////////////////
    // write channel and mode register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            aw_ready  <= 1'b0;
            b_valid   <= 1'b0;
            acc_clear <= 1'b0;
            mode      <= MODE_8X8;
        end else begin
            // one-cycle pulse on every accepted mode write, same value or not
            acc_clear <= wr_fire & wr_hit;
            if (b_valid && axil_req.bready) begin
                b_valid <= 1'b0;
            end
            if (wr_fire) begin
                aw_ready <= 1'b0;
                b_valid  <= 1'b1;
            end else if (!aw_ready && !b_valid && axil_req.awvalid && axil_req.wvalid) begin
                // address and data both present, nothing pending
                aw_ready <= 1'b1;
            end
            if (wr_fire && wr_hit && axil_req.wstrb[0]) begin
                mode <= prec_mode_t'(axil_req.wdata[1:0]);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read channel
    //////////////////////////////////////////////////////////////////////

    // arready comes up on the first cycle out of reset
    // and drops while a response waits for rready
    always_ff @(posedge clk) begin
        if (!nrst) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
        end else if (rd_fire) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b1;
        end else if (r_valid && axil_req.rready) begin
            r_valid  <= 1'b0;
            ar_ready <= 1'b1;
        end else if (!r_valid) begin
            ar_ready <= 1'b1;
        end
    end

    // response payload, captured at the accept
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            b_resp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            r_data <= rd_hit ? AXIL_DATA_W'(mode) : '0;
            r_resp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_comb begin
        axil_rsp.awready = aw_ready;
        axil_rsp.wready  = aw_ready;
        axil_rsp.bvalid  = b_valid;
        axil_rsp.bresp   = b_resp;
        axil_rsp.arready = ar_ready;
        axil_rsp.rvalid  = r_valid;
        axil_rsp.rdata   = r_data;
        axil_rsp.rresp   = r_resp;
    end

    // responses stay up until the manager takes them
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!nrst) (b_valid && !axil_req.bready) |=> b_valid
    ) else $error("bvalid dropped before bready");

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (!nrst) (r_valid && !axil_req.rready) |=> r_valid
    ) else $error("rvalid dropped before rready");

endmodule

// ==== hdl/fusion_mac_top.sv ====
`timescale 1ns/1ps

module fusion_mac_top (
    input  logic                  clk,
    input  logic                  nrst,
    input  fusion_pkg::axil_req_t axil_req,
    output fusion_pkg::axil_rsp_t axil_rsp,
    input  fusion_pkg::mac_in_t   mac_in,
    output fusion_pkg::acc_vec_t  sum
);
    import fusion_pkg::*;

    // configuration to datapath
    prec_mode_t   mode;
    logic         acc_clear;

    // fusion unit to accumulator
    product_vec_t product;
    logic         product_valid;

    // axi4-lite mode register and clear pulse
    mode_regs u_mode_regs (
        .clk       (clk),
        .nrst      (nrst),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .mode      (mode),
        .acc_clear (acc_clear)
    );

    // combinational multiplier array
    fusion_unit u_fusion_unit (
        .mode          (mode),
        .in            (mac_in),
        .product       (product),
        .product_valid (product_valid)
    );

    // sum-apart lanes
    lane_accumulator u_lane_acc (
        .clk           (clk),
        .nrst          (nrst),
        .mode          (mode),
        .acc_clear     (acc_clear),
        .product       (product),
        .product_valid (product_valid),
        .sum           (sum)
    );

endmodule

// ==== dv/fusion_mac_tb.sv ====
`timescale 1ns/1ps

module fusion_mac_tb;
    import fusion_pkg::*;

    localparam int CLK_PERIOD = 8;

    // what one table row does to the DUT
    typedef enum int {
        K_WRITE,
        K_READ,
        K_BAD_ADDR,
        K_MAC,
        K_RAND,
        K_IDLE
    } test_kind_t;

    // value is the write data, the expected read data, or {x, y} for fixed samples
    typedef struct {
        string       name;
        test_kind_t  kind;
        logic [31:0] value;
        int          count;
        logic [1:0]  resp;
    } test_entry_t;

    logic      clk;
    logic      nrst;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    mac_in_t   mac_in;
    acc_vec_t  sum;

    test_entry_t tests[$];
    int          table_len;
    logic [15:0] lfsr_state;
    // model state, tracked from the table alone
    logic [1:0]  model_mode;
    acc_vec_t    exp_sum;

    fusion_mac_top dut0 (
        .clk      (clk),
        .nrst     (nrst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .mac_in   (mac_in),
        .sum      (sum)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////
    // stimulus helpers and reference model
    ////////////////////////////////////////////////////////////////////////

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per operand bit
    task automatic random_operand(output operand_t v);
        v = '0;
        for (int i = 0; i < OPERAND_W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[OPERAND_W-2:0], lfsr_state[0]};
        end
    endtask

    // signed value of a w-bit field at lsb
    function automatic int field_val(input operand_t v, input int lsb, input int w);
        int r;
        r = int'(v >> lsb) & ((1 << w) - 1);
        if (r >= (1 << (w - 1))) begin
            r = r - (1 << w);
        end
        return r;
    endfunction

    // expected sum after one valid sample
    // lanes count from the bottom, lane 0 pairs the lowest fields
    function automatic acc_vec_t model_add(input logic [1:0] m, input acc_vec_t acc,
                                           input operand_t x, input operand_t y);
        acc_vec_t nxt;
        int       p;
        int       xf;
        int       yf;
        nxt = '0;
        case (m)
            MODE_8X8: begin
                p = field_val(x, 0, 8) * field_val(y, 0, 8);
                nxt[127:108] = acc[127:108] + p[19:0];
            end
            MODE_4X4: begin
                // lane i takes x nibble i/2 and y nibble i%2
                for (int i = 0; i < 4; i++) begin
                    p = field_val(x, 4 * (i / 2), 4) * field_val(y, 4 * (i % 2), 4);
                    nxt[80 + 12 * i +: 12] = acc[80 + 12 * i +: 12] + p[11:0];
                end
            end
            MODE_2X2: begin
                // block i/4 picks the nibbles, i%4 picks fields inside them
                for (int i = 0; i < 16; i++) begin
                    xf = 2 * (i / 8) + (i % 4) / 2;
                    yf = 2 * ((i / 4) % 2) + i % 2;
                    p = field_val(x, 2 * xf, 2) * field_val(y, 2 * yf, 2);
                    nxt[8 * i +: 8] = acc[8 * i +: 8] + p[7:0];
                end
            end
            default: nxt = '0;
        endcase
        return nxt;
    endfunction

    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_value(input string name, input acc_vec_t expected,
                               input acc_vec_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // axi4-lite manager
    ////////////////////////////////////////////////////////////////////////

    // x and y go out as a valid sample in the cycle right after the accept
    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr,
                              input logic [AXIL_DATA_W-1:0] data,
                              input operand_t x, input operand_t y,
                              output logic [1:0] resp);
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= '1;
        axil_req.bready  <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.awready) @(negedge clk);
        // wready comes up in the same cycle as awready
        assert (axil_rsp.wready) else begin
            $display("wready did not rise together with awready");
            fail_run();
        end
        // accept edge
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        mac_in.valid     <= 1'b1;
        mac_in.x         <= x;
        mac_in.y         <= y;
        @(negedge clk);
        while (!axil_rsp.bvalid) @(negedge clk);
        resp = axil_rsp.bresp;
        @(posedge clk);
        axil_req.bready <= 1'b0;
        mac_in.valid    <= 1'b0;
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr,
                             output logic [AXIL_DATA_W-1:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        axil_req.rready  <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid) @(negedge clk);
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    // back to back samples, sum checked one cycle after each
    // idle rows keep valid low with random operands on the bus
    task automatic run_samples(input test_entry_t t);
        operand_t x;
        operand_t y;
        for (int n = 0; n < t.count; n++) begin
            if (t.kind == K_MAC) begin
                x = t.value[15:8];
                y = t.value[7:0];
            end else begin
                random_operand(x);
                random_operand(y);
            end
            @(posedge clk);
            mac_in.valid <= (t.kind != K_IDLE);
            mac_in.x     <= x;
            mac_in.y     <= y;
            @(negedge clk);
            check_value(t.name, exp_sum, sum);
            if (t.kind != K_IDLE) begin
                exp_sum = model_add(model_mode, exp_sum, x, y);
            end
        end
        @(posedge clk);
        mac_in.valid <= 1'b0;
        @(negedge clk);
        check_value(t.name, exp_sum, sum);
    endtask

    task automatic add_test(input string name, input test_kind_t kind,
                            input logic [31:0] value, input int count, input logic [1:0] resp);
        test_entry_t t;
        t.name  = name;
        t.kind  = kind;
        t.value = value;
        t.count = count;
        t.resp  = resp;
        tests.push_back(t);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // test table
    ////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        add_test("reset_idle",      K_IDLE,     32'd0,      3,  RESP_OKAY);
        add_test("reset_mode",      K_READ,     32'd2,      1,  RESP_OKAY);
        add_test("full_rand",       K_RAND,     32'd0,      24, RESP_OKAY);
        add_test("full_neg",        K_MAC,      32'h7F81,   4,  RESP_OKAY);
        // 40 x 16384 runs past the 20-bit lane
        add_test("full_wrap",       K_MAC,      32'h8080,   40, RESP_OKAY);
        add_test("nib_mode",        K_WRITE,    32'd1,      1,  RESP_OKAY);
        add_test("nib_read",        K_READ,     32'd1,      1,  RESP_OKAY);
        add_test("nib_rand",        K_RAND,     32'd0,      24, RESP_OKAY);
        add_test("nib_wrap",        K_MAC,      32'h8888,   40, RESP_OKAY);
        add_test("nib_mixed",       K_MAC,      32'h7F18,   4,  RESP_OKAY);
        add_test("field_mode",      K_WRITE,    32'd0,      1,  RESP_OKAY);
        // every field is 2'b10
        add_test("field_neg2",      K_MAC,      32'hAAAA,   40, RESP_OKAY);
        add_test("field_mixed",     K_MAC,      32'h9A26,   6,  RESP_OKAY);
        add_test("field_rand",      K_RAND,     32'd0,      32, RESP_OKAY);
        add_test("field_rewrite",   K_WRITE,    32'd0,      1,  RESP_OKAY);
        add_test("field_after",     K_RAND,     32'd0,      8,  RESP_OKAY);
        add_test("field_idle",      K_IDLE,     32'd0,      6,  RESP_OKAY);
        add_test("bad_addr",        K_BAD_ADDR, 32'd1,      1,  RESP_SLVERR);
        add_test("bad_addr_mode",   K_READ,     32'd0,      1,  RESP_OKAY);
        add_test("field_keep",      K_RAND,     32'd0,      4,  RESP_OKAY);
        add_test("bad_mode",        K_WRITE,    32'd3,      1,  RESP_OKAY);
        add_test("bad_mode_read",   K_READ,     32'd3,      1,  RESP_OKAY);
        add_test("bad_mode_rand",   K_RAND,     32'd0,      6,  RESP_OKAY);
        add_test("full_again",      K_WRITE,    32'd2,      1,  RESP_OKAY);
        add_test("full_again_rand", K_RAND,     32'd0,      8,  RESP_OKAY);
        table_len = tests.size();
    endtask

    initial begin
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             resp;
        operand_t               x;
        operand_t               y;
        clk        = 1'b0;
        nrst       = 1'b0;
        axil_req   = '0;
        mac_in     = '0;
        lfsr_state = 16'd62;
        model_mode = MODE_8X8;
        exp_sum    = '0;
        build_table();
        repeat (3) @(posedge clk);
        nrst <= 1'b1;

        foreach (tests[i]) begin
            case (tests[i].kind)
                K_WRITE: begin
                    // the sample on the clear cycle must be dropped
                    random_operand(x);
                    random_operand(y);
                    axil_write(MODE_ADDR, tests[i].value, x, y, resp);
                    check_value(tests[i].name, acc_vec_t'(tests[i].resp), acc_vec_t'(resp));
                    model_mode = tests[i].value[1:0];
                    exp_sum    = '0;
                    @(negedge clk);
                    check_value(tests[i].name, exp_sum, sum);
                end
                K_READ: begin
                    axil_read(MODE_ADDR, rdata, resp);
                    check_value(tests[i].name, acc_vec_t'(tests[i].resp), acc_vec_t'(resp));
                    check_value(tests[i].name, acc_vec_t'(tests[i].value), acc_vec_t'(rdata));
                end
                K_BAD_ADDR: begin
                    // no clear here so the trailing sample accumulates
                    random_operand(x);
                    random_operand(y);
                    axil_write(4'd4, tests[i].value, x, y, resp);
                    check_value(tests[i].name, acc_vec_t'(tests[i].resp), acc_vec_t'(resp));
                    exp_sum = model_add(model_mode, exp_sum, x, y);
                    axil_read(4'd4, rdata, resp);
                    check_value(tests[i].name, acc_vec_t'(tests[i].resp), acc_vec_t'(resp));
                    check_value(tests[i].name, '0, acc_vec_t'(rdata));
                    @(negedge clk);
                    check_value(tests[i].name, exp_sum, sum);
                end
                default: run_samples(tests[i]);
            endcase
        end

        $display("Finished with no errors");
        $finish;
    end

    // budget of 20 cycles per row or per sample
    initial begin
        int budget;
        wait (table_len > 0);
        budget = 0;
        foreach (tests[i]) begin
            budget += ((tests[i].count > 0) ? tests[i].count : 1) * 20;
        end
        #((budget + 10) * CLK_PERIOD);
        $display("watchdog expired before the test table finished");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

endmodule

// ==== files.f ====
hdl/fusion_pkg.sv
hdl/bit_brick.sv
hdl/fusion_block.sv
hdl/fusion_unit.sv
hdl/lane_accumulator.sv
hdl/mode_regs.sv
hdl/fusion_mac_top.sv
dv/fusion_mac_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fusion mac testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 \
    --top-module fusion_mac_tb \
    -f files.f \
    -o fusion_mac_sim

# a fatal stop exits nonzero and the log search gives the result
./obj_dir/fusion_mac_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
